// ==== logic/usb_spec_pkg.sv ====
package usb_spec_pkg;

  // PID code as sent on the wire, check nibble not included.
  typedef logic [3:0] pid_t;

  // Device to host PIDs.
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_STALL = 4'b1110;

  // Coding group lives in the two low PID bits.
  localparam logic [1:0] PIDGROUP_DATA      = 2'b11;
  localparam logic [1:0] PIDGROUP_HANDSHAKE = 2'b10;

  // Line state as {D+, D-}.
  typedef logic [1:0] line_t;

  localparam line_t LINE_J   = 2'b10;
  localparam line_t LINE_K   = 2'b01;
  localparam line_t LINE_SE0 = 2'b00;

  // KJKJKJKK on the line, i.e. seven zeros then a one, LSB first.
  localparam logic [7:0] SYNC_BYTE = 8'h80;

  // A zero is stuffed after this many ones in a row.
  localparam int NRZI_MAX_ONES = 6;

  // CRC16 for data payloads, x^16 + x^15 + x^2 + 1, bit reversed.
  localparam logic [15:0] CRC16_SEED      = 16'hFFFF;
  localparam logic [15:0] CRC16_POLY_REFL = 16'hA001;

endpackage

// ==== logic/usb_tx_pkg.sv ====
package usb_tx_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] crc16_t;

  // Byte sequencing in the serializer.
  typedef enum logic [2:0] {
    SER_IDLE,
    SER_SYNC,
    SER_PID,
    SER_DATA,
    SER_CRC_LO,
    SER_CRC_HI,
    SER_WAIT_EOP
  } ser_state_e;

  // Line encoder phases; each EOP state is one bit time.
  typedef enum logic [2:0] {
    ENC_IDLE,
    ENC_BITS,
    ENC_SE0_A,
    ENC_SE0_B,
    ENC_J
  } enc_state_e;

endpackage

// ==== logic/usb_tx_bit_if.sv ====
`timescale 1ns/1ps

interface usb_tx_bit_if;

  // Data bit to send on the next strobe.
  logic tx_bit;
  // High from acceptance until the EOP is done.
  logic active;
  // Marks the final bit of the final byte.
  logic last_bit;
  // Encoder inserts a zero on this strobe, serializer holds.
  logic stuff;
  // Closing J bit has ended.
  logic eop_done;

  modport ser (output tx_bit, output active, output last_bit,
               input stuff, input eop_done);

  modport enc (input tx_bit, input active, input last_bit,
               output stuff, output eop_done);

endinterface

// ==== logic/usb_tx_pid_decode.sv ====
`timescale 1ns/1ps

module usb_tx_pid_decode
  import usb_spec_pkg::*, usb_tx_pkg::*;
(
  input  logic  i_clk_48MHz,
  input  logic  i_rst,
  input  logic  i_strobe_12MHz,
  input  logic  i_valid,
  input  pid_t  i_pid,
  input  logic  i_busy,
  output logic  o_ready,
  output logic  o_start,
  output byte_t o_pid_byte,
  output logic  o_is_data,
  output logic  o_pid_err
);

  logic [1:0] pid_grp;
  logic       legal_data;
  logic       legal_hs;
  logic       req;

  // Group first, then the exact codes this device may send.
  assign pid_grp    = i_pid[1:0];
  assign legal_data = (pid_grp == PIDGROUP_DATA) &&
                      ((i_pid == PID_DATA0) || (i_pid == PID_DATA1));
  assign legal_hs   = (pid_grp == PIDGROUP_HANDSHAKE) &&
                      ((i_pid == PID_ACK) || (i_pid == PID_NAK) || (i_pid == PID_STALL));

  // A request only counts on a strobe while nothing is in flight.
  assign req     = i_strobe_12MHz && i_valid && o_ready;
  assign o_start = req && (legal_data || legal_hs);
  assign o_ready = !i_busy;

  // PID byte carries its own complement in the upper nibble.
  always_ff @(posedge i_clk_48MHz) begin
    if (o_start) begin
      o_pid_byte <= {~i_pid, i_pid};
      o_is_data  <= legal_data;
    end
  end

  // Single cycle flag for a rejected PID.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      o_pid_err <= 1'b0;
    end else begin
      o_pid_err <= req && !(legal_data || legal_hs);
    end
  end

endmodule

// ==== logic/usb_tx_serializer.sv ====
`timescale 1ns/1ps

module usb_tx_serializer
  import usb_spec_pkg::*, usb_tx_pkg::*;
#(
  parameter int MAX_PKT = 8
) (
  input  logic                       i_clk_48MHz,
  input  logic                       i_rst,
  input  logic                       i_strobe_12MHz,
  input  logic                       i_wr_en,
  input  logic [$clog2(MAX_PKT)-1:0] i_wr_idx,
  input  byte_t                      i_wr_byte,
  input  logic                       i_start,
  input  byte_t                      i_pid_byte,
  input  logic                       i_is_data,
  output logic                       o_busy,
  output logic                       o_inflight,
  usb_tx_bit_if.ser                  bit_if
);

  localparam int IDX_W = $clog2(MAX_PKT);
  // Byte counts run from 0 to MAX_PKT inclusive.
  localparam int CNT_W = $clog2(MAX_PKT + 1);

  byte_t            mem_q [MAX_PKT];
  logic [CNT_W-1:0] wr_cnt_q;
  logic [CNT_W-1:0] len_q;
  logic [CNT_W-1:0] idx_q;
  ser_state_e       state_q;
  byte_t            shift_q;
  byte_t            next_byte;
  logic [2:0]       bit_cnt_q;
  crc16_t           crc_q;
  crc16_t           crc_next;
  logic             active_q;
  logic             shifting;
  logic             byte_end;
  logic             final_byte;

  // Payload buffer, filled by the controller before the request.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_wr_en) begin
      mem_q[i_wr_idx] <= i_wr_byte;
    end
  end

  // Writes since the last acceptance give the payload length.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst || i_start) begin
      wr_cnt_q <= '0;
    end else if (i_wr_en) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge i_clk_48MHz) begin
    if (i_start) begin
      len_q <= wr_cnt_q;
    end
  end

  // Bits only move while the line is taking them.
  assign shifting = i_strobe_12MHz && active_q && !bit_if.stuff &&
                    (state_q != SER_IDLE) && (state_q != SER_WAIT_EOP);
  assign byte_end = (bit_cnt_q == 3'd7);

  // Handshakes end after the PID, data packets after the CRC.
  assign final_byte = ((state_q == SER_PID) && !i_is_data) || (state_q == SER_CRC_HI);

  // Reflected CRC16 step on the bit leaving the shift register.
  assign crc_next = {1'b0, crc_q[15:1]} ^
                    ((crc_q[0] ^ shift_q[0]) ? CRC16_POLY_REFL : 16'h0000);

  // Byte to load at the end of the current one.
  always_comb begin
    case (state_q)
      SER_PID:    next_byte = (len_q == '0) ? ~crc_q[7:0] : mem_q[0];
      SER_DATA:   next_byte = (idx_q == len_q) ? ~crc_next[7:0] : mem_q[idx_q[IDX_W-1:0]];
      SER_CRC_LO: next_byte = ~crc_q[15:8];
      default:    next_byte = i_pid_byte;
    endcase
  end

  // Sequencing of the packet fields.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      state_q   <= SER_IDLE;
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
      idx_q     <= '0;
    end else if (i_strobe_12MHz) begin
      if (i_start) begin
        state_q   <= SER_SYNC;
        active_q  <= 1'b1;
        bit_cnt_q <= '0;
        idx_q     <= '0;
      end else if (bit_if.eop_done) begin
        state_q  <= SER_IDLE;
        active_q <= 1'b0;
      end else if (shifting) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
        if (byte_end) begin
          case (state_q)
            SER_SYNC: state_q <= SER_PID;
            SER_PID: begin
              if (!i_is_data) begin
                state_q <= SER_WAIT_EOP;
              end else if (len_q == '0) begin
                // zero length packet, CRC only
                state_q <= SER_CRC_LO;
              end else begin
                state_q <= SER_DATA;
                idx_q   <= 1'b1;
              end
            end
            SER_DATA: begin
              if (idx_q == len_q) begin
                state_q <= SER_CRC_LO;
              end else begin
                idx_q <= idx_q + 1'b1;
              end
            end
            SER_CRC_LO: state_q <= SER_CRC_HI;
            SER_CRC_HI: state_q <= SER_WAIT_EOP;
            default:    state_q <= state_q;
          endcase
        end
      end
    end
  end

  // Shift register and CRC; the CRC covers payload bits only.
  always_ff @(posedge i_clk_48MHz) begin
    if (i_strobe_12MHz) begin
      if (i_start) begin
        shift_q <= SYNC_BYTE;
        crc_q   <= CRC16_SEED;
      end else if (shifting) begin
        if (state_q == SER_DATA) begin
          crc_q <= crc_next;
        end
        shift_q <= byte_end ? next_byte : {1'b0, shift_q[7:1]};
      end
    end
  end

  assign bit_if.tx_bit   = shift_q[0];
  assign bit_if.active   = active_q;
  assign bit_if.last_bit = byte_end && final_byte;

  // Busy doubles as the pad output enable.
  assign o_busy     = active_q;
  assign o_inflight = active_q;

endmodule

// ==== logic/usb_tx_line_encoder.sv ====
`timescale 1ns/1ps

module usb_tx_line_encoder
  import usb_spec_pkg::*, usb_tx_pkg::*;
(
  input  logic        i_clk_48MHz,
  input  logic        i_rst,
  input  logic        i_strobe_12MHz,
  usb_tx_bit_if.enc   bit_if,
  output logic        o_dp,
  output logic        o_dn,
  output logic        o_eop_done
);

  localparam logic [2:0] ONES_LIMIT = 3'(NRZI_MAX_ONES);

  enc_state_e state_q;
  line_t      line_q;
  line_t      nrzi_line;
  logic [2:0] ones_q;
  logic       tail_q;
  logic       send_bit;

  // Stuffing is due once the ones counter reaches the limit.
  assign bit_if.stuff = (state_q == ENC_BITS) && (ones_q == ONES_LIMIT);
  assign send_bit     = bit_if.stuff ? 1'b0 : bit_if.tx_bit;

  // NRZI: a one keeps the line, a zero flips J and K.
  assign nrzi_line = send_bit ? line_q : ((line_q == LINE_J) ? LINE_K : LINE_J);

  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      state_q <= ENC_IDLE;
      line_q  <= LINE_J;
      ones_q  <= '0;
      tail_q  <= 1'b0;
    end else if (i_strobe_12MHz) begin
      case (state_q)
        ENC_IDLE, ENC_BITS: begin
          // Any pending stuff bit goes out before the EOP.
          if (tail_q && !bit_if.stuff) begin
            state_q <= ENC_SE0_A;
            line_q  <= LINE_SE0;
            ones_q  <= '0;
            tail_q  <= 1'b0;
          end else if (bit_if.active) begin
            state_q <= ENC_BITS;
            line_q  <= nrzi_line;
            ones_q  <= send_bit ? ones_q + 3'd1 : 3'd0;
            tail_q  <= tail_q || (bit_if.last_bit && !bit_if.stuff);
          end
        end
        ENC_SE0_A: state_q <= ENC_SE0_B;
        ENC_SE0_B: begin
          // Line returns to idle J for the final bit time.
          state_q <= ENC_J;
          line_q  <= LINE_J;
        end
        ENC_J:   state_q <= ENC_IDLE;
        default: state_q <= ENC_IDLE;
      endcase
    end
  end

  // Pulses on the strobe that closes the J bit.
  assign o_eop_done      = i_strobe_12MHz && (state_q == ENC_J);
  assign bit_if.eop_done = o_eop_done;

  assign {o_dp, o_dn} = line_q;

endmodule

// ==== logic/usb_fs_tx_top.sv ====
`timescale 1ns/1ps

module usb_fs_tx_top
  import usb_spec_pkg::*, usb_tx_pkg::*;
#(
  parameter int MAX_PKT = 8
) (
  input  logic                       i_clk_48MHz,
  input  logic                       i_rst,
  input  logic                       i_strobe_12MHz,
  input  logic                       i_valid,
  input  pid_t                       i_pid,
  output logic                       o_ready,
  input  logic                       i_wr_en,
  input  logic [$clog2(MAX_PKT)-1:0] i_wr_idx,
  input  byte_t                      i_wr_byte,
  output logic                       o_dp,
  output logic                       o_dn,
  output logic                       o_inflight,
  output logic                       o_eop_done,
  output logic                       o_pid_err
);

  logic  start;
  logic  is_data;
  logic  busy;
  byte_t pid_byte;

  // Serial bit stream between serializer and encoder.
  usb_tx_bit_if bit_if ();

  // Decode stage.
  usb_tx_pid_decode u_decode (
    .i_clk_48MHz   (i_clk_48MHz),
    .i_rst         (i_rst),
    .i_strobe_12MHz(i_strobe_12MHz),
    .i_valid       (i_valid),
    .i_pid         (i_pid),
    .i_busy        (busy),
    .o_ready       (o_ready),
    .o_start       (start),
    .o_pid_byte    (pid_byte),
    .o_is_data     (is_data),
    .o_pid_err     (o_pid_err)
  );

  // Execute stage.
  usb_tx_serializer #(.MAX_PKT(MAX_PKT)) u_serializer (
    .i_clk_48MHz   (i_clk_48MHz),
    .i_rst         (i_rst),
    .i_strobe_12MHz(i_strobe_12MHz),
    .i_wr_en       (i_wr_en),
    .i_wr_idx      (i_wr_idx),
    .i_wr_byte     (i_wr_byte),
    .i_start       (start),
    .i_pid_byte    (pid_byte),
    .i_is_data     (is_data),
    .o_busy        (busy),
    .o_inflight    (o_inflight),
    .bit_if        (bit_if.ser)
  );

  // Result stage drives the pair.
  usb_tx_line_encoder u_encoder (
    .i_clk_48MHz   (i_clk_48MHz),
    .i_rst         (i_rst),
    .i_strobe_12MHz(i_strobe_12MHz),
    .bit_if        (bit_if.enc),
    .o_dp          (o_dp),
    .o_dn          (o_dn),
    .o_eop_done    (o_eop_done)
  );

endmodule

// ==== dv/usb_fs_tx_checker.sv ====
`timescale 1ns/1ps

module usb_fs_tx_checker (
  input logic i_clk_48MHz,
  input logic i_rst,
  input logic i_strobe_12MHz,
  input logic i_dp,
  input logic i_dn,
  input logic i_ready,
  input logic i_inflight,
  input logic i_eop_done,
  input logic i_pid_err
);

  localparam logic [1:0] LINE_J   = 2'b10;
  localparam logic [1:0] LINE_SE0 = 2'b00;
  localparam logic [7:0] SYNC     = 8'h80;

  logic [7:0] exp_q [$];
  int         len_q [$];
  logic [7:0] got_q [$];
  int         pid_err_exp = 0;
  int         rej_errs = 0;
  int         err_cnt = 0;
  int         test_cnt = 0;
  int         fail_cnt = 0;
  int         pkt_err = 0;
  logic       in_pkt = 1'b0;
  logic       rst_q = 1'b1;
  logic       inflight_q = 1'b0;
  logic [1:0] prev_line = 2'b10;
  logic [1:0] line;
  logic       nrzi_bit;
  logic [7:0] cur = 8'h00;
  int         ones = 0;
  int         nbits = 0;
  int         se0_n = 0;

  // Expected packets arrive from the testbench one byte at a time.
  task automatic add_expected(input logic [7:0] b);
    exp_q.push_back(b);
  endtask

  task automatic close_expected(input int n);
    len_q.push_back(n);
  endtask

  // Opens the window for a refused request.
  task automatic expect_pid_err();
    pid_err_exp++;
    rej_errs = err_cnt;
  endtask

  // Line must still be idle once the refused request has been watched.
  task automatic close_reject();
    if (in_pkt) begin
      text_error("the line left J after the token PID was refused");
    end
    end_test("token PID refused", rej_errs);
  endtask

  function automatic int pending();
    return len_q.size() + pid_err_exp;
  endfunction

  task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] exp);
    $display("ERROR: %s got 0x%02h, expected 0x%02h", name, got, exp);
    err_cnt++;
  endtask

  task automatic text_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d, %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d, %s: FAIL", test_cnt, name);
    end
  endtask

  task automatic check_reset();
    int errs;
    errs = err_cnt;
    if ({i_dp, i_dn} != LINE_J) begin
      value_error("o_dp/o_dn", {6'd0, i_dp, i_dn}, {6'd0, LINE_J});
    end
    if (!i_ready) begin
      text_error("o_ready is low after reset");
    end
    if (i_inflight || i_eop_done) begin
      text_error("o_inflight or o_eop_done is high after reset");
    end
    end_test("state after reset", errs);
  endtask

  // Compares the bytes after SYNC with the next expected packet.
  task automatic finish_packet();
    int         n;
    int         i;
    logic [7:0] e;
    logic [7:0] pid_b;
    if (len_q.size() == 0) begin
      text_error("a packet appeared on the line with no legal request pending");
      end_test("unexpected packet", pkt_err);
    end else begin
      n     = len_q.pop_front();
      pid_b = exp_q[0];
      if (nbits % 8 != 0) begin
        text_error($sformatf("packet ended after %0d bits, off a byte boundary", nbits));
      end
      if (got_q.size() != n + 1) begin
        text_error($sformatf("packet carried %0d bytes after SYNC, expected %0d",
                             got_q.size() - 1, n));
      end
      if (got_q.size() > 0 && got_q[0] != SYNC) begin
        value_error("o_dp/o_dn SYNC", got_q[0], SYNC);
      end
      for (i = 0; i < n; i++) begin
        e = exp_q.pop_front();
        if (i + 1 < got_q.size() && got_q[i + 1] != e) begin
          value_error($sformatf("o_dp/o_dn byte %0d", i), got_q[i + 1], e);
        end
      end
      end_test($sformatf("PID byte 0x%02h with %0d bytes", pid_b, n), pkt_err);
    end
  endtask

  // One NRZI bit per strobe.
  // No change is a one and a change is a zero.
  task automatic sample_line();
    line = {i_dp, i_dn};
    if (i_eop_done && !(in_pkt && se0_n == 2 && line == LINE_J)) begin
      text_error("o_eop_done pulsed outside the closing J bit");
    end
    if (!in_pkt && line != LINE_J) begin
      in_pkt  = 1'b1;
      ones    = 0;
      nbits   = 0;
      se0_n   = 0;
      pkt_err = err_cnt;
      got_q.delete();
    end
    if (in_pkt) begin
      if (line == LINE_SE0) begin
        se0_n++;
      end else if (se0_n > 0) begin
        if (se0_n != 2 || line != LINE_J) begin
          text_error("EOP was not two SE0 bit times followed by J");
        end
        if (!i_eop_done) begin
          text_error("o_eop_done did not pulse at the end of the EOP");
        end
        finish_packet();
        in_pkt = 1'b0;
      end else begin
        nrzi_bit = (line == prev_line);
        if (ones == 6) begin
          // Stuffed zero is dropped.
          if (nrzi_bit) begin
            text_error("seventh one in a row, a stuffed zero is missing");
          end
          ones = 0;
        end else begin
          ones = nrzi_bit ? ones + 1 : 0;
          cur  = {nrzi_bit, cur[7:1]};
          nbits++;
          if (nbits % 8 == 0) begin
            got_q.push_back(cur);
          end
        end
      end
    end
    prev_line = line;
  endtask

  always @(posedge i_clk_48MHz) begin
    if (rst_q && !i_rst) begin
      check_reset();
    end
    if (!i_rst) begin
      if (i_inflight && !inflight_q && len_q.size() == 0) begin
        text_error("o_inflight rose with no legal request pending");
      end
      if (i_pid_err) begin
        if (pid_err_exp > 0) begin
          pid_err_exp--;
        end else begin
          text_error("o_pid_err pulsed although no illegal PID was requested");
        end
      end
      if (i_strobe_12MHz) begin
        sample_line();
      end
    end
    rst_q      = i_rst;
    inflight_q = i_inflight;
  end

endmodule

// ==== dv/usb_fs_tx_assert.sv ====
`timescale 1ns/1ps

module usb_fs_tx_assert (
  input logic i_clk_48MHz,
  input logic i_rst,
  input logic i_ready,
  input logic i_inflight,
  input logic i_eop_done,
  input logic i_dp,
  input logic i_dn
);

  int err_cnt = 0;

  // Ready is the idle flag.
  ready_inverse: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    i_ready == !i_inflight)
    else begin
      err_cnt++;
      $error("o_ready is not the inverse of o_inflight");
    end

  eop_in_packet: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    i_eop_done |-> i_inflight)
    else begin
      err_cnt++;
      $error("o_eop_done while no packet is in flight");
    end

  // SE1 is never a legal line state.
  no_se1: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    !(i_dp && i_dn))
    else begin
      err_cnt++;
      $error("o_dp and o_dn both high");
    end

  // Packet only ends after its EOP.
  end_after_eop: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    $fell(i_inflight) |-> $past(i_eop_done))
    else begin
      err_cnt++;
      $error("o_inflight fell without o_eop_done");
    end

endmodule

// ==== dv/usb_fs_tx_tb.sv ====
`timescale 1ns/1ps

module usb_fs_tx_tb;

  localparam int MAX_PKT = 8;
  // Longest packet is SYNC, PID, full payload and CRC, with worst case stuffing and EOP.
  localparam int FIELD_BITS  = 8 + 8 + 8 * MAX_PKT + 16;
  localparam int WORST_BITS  = FIELD_BITS + FIELD_BITS / 6 + 3;
  localparam int NUM_PKTS    = 28;
  localparam int TIMEOUT_CYC = 2 * WORST_BITS * 4 * NUM_PKTS;

  // PID codes from the USB 2.0 PID table.
  localparam logic [3:0] PID_OUT   = 4'b0001;
  localparam logic [3:0] PID_ACK   = 4'b0010;
  localparam logic [3:0] PID_NAK   = 4'b1010;
  localparam logic [3:0] PID_STALL = 4'b1110;
  localparam logic [3:0] PID_DATA0 = 4'b0011;
  localparam logic [3:0] PID_DATA1 = 4'b1011;

  logic       clk_48MHz;
  logic       rst;
  logic       strobe_12MHz = 1'b0;
  logic [1:0] strobe_cnt = 2'd0;
  logic       valid;
  logic [3:0] req_pid;
  logic       wr_en;
  logic [2:0] wr_idx;
  logic [7:0] wr_byte;
  logic       ready;
  logic       dp;
  logic       dn;
  logic       inflight;
  logic       eop_done;
  logic       pid_err;
  logic [7:0] payload [MAX_PKT];
  logic [7:0] ref_q [$];

  usb_fs_tx_top #(.MAX_PKT(MAX_PKT)) UUT (
    .i_clk_48MHz   (clk_48MHz),
    .i_rst         (rst),
    .i_strobe_12MHz(strobe_12MHz),
    .i_valid       (valid),
    .i_pid         (req_pid),
    .o_ready       (ready),
    .i_wr_en       (wr_en),
    .i_wr_idx      (wr_idx),
    .i_wr_byte     (wr_byte),
    .o_dp          (dp),
    .o_dn          (dn),
    .o_inflight    (inflight),
    .o_eop_done    (eop_done),
    .o_pid_err     (pid_err)
  );

  usb_fs_tx_checker u_checker (
    .i_clk_48MHz   (clk_48MHz),
    .i_rst         (rst),
    .i_strobe_12MHz(strobe_12MHz),
    .i_dp          (dp),
    .i_dn          (dn),
    .i_ready       (ready),
    .i_inflight    (inflight),
    .i_eop_done    (eop_done),
    .i_pid_err     (pid_err)
  );

  bind usb_fs_tx_top usb_fs_tx_assert u_assert (
    .i_clk_48MHz(i_clk_48MHz),
    .i_rst      (i_rst),
    .i_ready    (o_ready),
    .i_inflight (o_inflight),
    .i_eop_done (o_eop_done),
    .i_dp       (o_dp),
    .i_dn       (o_dn)
  );

  initial begin
    clk_48MHz = 1'b0;
    forever #4 clk_48MHz = ~clk_48MHz;
  end

  // One bit time is four clocks.
  always @(posedge clk_48MHz) begin
    strobe_cnt   <= strobe_cnt + 2'd1;
    strobe_12MHz <= (strobe_cnt == 2'd3);
  end

  // Expected bytes after SYNC.
  // CRC16 runs LSB first over the payload and goes out inverted, low byte first.
  function automatic void build_expected(input logic [3:0] pid, input int len);
    logic [15:0] crc;
    logic        fb;
    int          i;
    int          b;
    ref_q.delete();
    ref_q.push_back({~pid, pid});
    if (pid[1:0] == 2'b11) begin
      crc = 16'hFFFF;
      for (i = 0; i < len; i++) begin
        ref_q.push_back(payload[i]);
        for (b = 0; b < 8; b++) begin
          fb  = crc[0] ^ payload[i][b];
          // Reflected form of x^16 + x^15 + x^2 + 1.
          crc = {1'b0, crc[15:1]} ^ (fb ? 16'hA001 : 16'h0000);
        end
      end
      crc = ~crc;
      ref_q.push_back(crc[7:0]);
      ref_q.push_back(crc[15:8]);
    end
  endfunction

  task automatic queue_expected(input logic [3:0] pid, input int len);
    int k;
    build_expected(pid, len);
    for (k = 0; k < ref_q.size(); k++) begin
      u_checker.add_expected(ref_q[k]);
    end
    u_checker.close_expected(ref_q.size());
  endtask

  task automatic load_payload(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      @(posedge clk_48MHz);
      wr_en   <= 1'b1;
      wr_idx  <= 3'(i);
      wr_byte <= payload[i];
    end
    @(posedge clk_48MHz);
    wr_en <= 1'b0;
  endtask

  // Acceptance shows as o_ready going low.
  task automatic wait_accept();
    do @(posedge clk_48MHz); while (ready);
  endtask

  task automatic send_packet(input logic [3:0] pid, input int len);
    while (!ready) @(posedge clk_48MHz);
    load_payload(len);
    queue_expected(pid, len);
    @(posedge clk_48MHz);
    valid   <= 1'b1;
    req_pid <= pid;
    wait_accept();
    valid <= 1'b0;
  endtask

  // Token PID must be refused with the line left idle.
  task automatic reject_token();
    while (!ready) @(posedge clk_48MHz);
    u_checker.expect_pid_err();
    @(posedge clk_48MHz);
    valid   <= 1'b1;
    req_pid <= PID_OUT;
    do @(posedge clk_48MHz); while (!pid_err);
    valid <= 1'b0;
    // Watch the idle line for a while.
    repeat (64) @(posedge clk_48MHz);
    u_checker.close_reject();
  endtask

  // Second request stays asserted while the first one is on the line.
  task automatic held_request();
    int i;
    for (i = 0; i < MAX_PKT; i++) begin
      payload[i] = 8'($urandom);
    end
    while (!ready) @(posedge clk_48MHz);
    load_payload(6);
    queue_expected(PID_DATA1, 6);
    queue_expected(PID_ACK, 0);
    @(posedge clk_48MHz);
    valid   <= 1'b1;
    req_pid <= PID_DATA1;
    wait_accept();
    req_pid <= PID_ACK;
    do @(posedge clk_48MHz); while (!ready);
    wait_accept();
    valid <= 1'b0;
  endtask

  initial begin
    int n;
    int i;
    int len;
    rst     = 1'b1;
    valid   = 1'b0;
    req_pid = 4'd0;
    wr_en   = 1'b0;
    wr_idx  = 3'd0;
    wr_byte = 8'd0;
    void'($urandom(32'h8f43));
    repeat (2) @(posedge clk_48MHz);
    rst <= 1'b0;
    send_packet(PID_ACK, 0);
    send_packet(PID_NAK, 0);
    send_packet(PID_STALL, 0);
    for (n = 0; n < 20; n++) begin
      len = $urandom_range(0, MAX_PKT);
      for (i = 0; i < MAX_PKT; i++) begin
        payload[i] = 8'($urandom);
      end
      send_packet(n[0] ? PID_DATA1 : PID_DATA0, len);
    end
    // All ones payload forces stuffing.
    for (i = 0; i < MAX_PKT; i++) begin
      payload[i] = 8'hFF;
    end
    send_packet(PID_DATA0, MAX_PKT);
    send_packet(PID_DATA1, 3);
    reject_token();
    held_request();
    while (u_checker.pending() != 0) @(posedge clk_48MHz);
    repeat (8) @(posedge clk_48MHz);
    $display("%0d tests run, %0d failing, %0d checker errors, %0d assertion errors",
             u_checker.test_cnt, u_checker.fail_cnt, u_checker.err_cnt,
             UUT.u_assert.err_cnt);
    if (u_checker.err_cnt == 0 && UUT.u_assert.err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_48MHz);
    $display("timeout after %0d clock cycles, the DUT stopped finishing packets",
             TIMEOUT_CYC);
    $display("test failed");
    $finish;
  end

endmodule

// ==== build.f ====
logic/usb_spec_pkg.sv
logic/usb_tx_pkg.sv
logic/usb_tx_bit_if.sv
logic/usb_tx_pid_decode.sv
logic/usb_tx_serializer.sv
logic/usb_tx_line_encoder.sv
logic/usb_fs_tx_top.sv
dv/usb_fs_tx_checker.sv
dv/usb_fs_tx_assert.sv
dv/usb_fs_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the USB FS transmit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=usb_fs_tx_sim

verilator --binary --timing --assert -Wno-fatal --top-module usb_fs_tx_tb \
  -f build.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
